//--- common/exec_defines.svh
/*
  Width parameters for the execute stage.
  Include this header wherever a data, sequence-number or
  physical-register width is needed to size a signal.
*/

`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// Data and address width
`define EXEC_XLEN 32

// In-flight sequence number, tags every micro-op
`define EXEC_SEQ_NUM_BITS 6

// Physical register index
`define EXEC_PHYS_ADDR_BITS 6

// Architectural register index is fixed by the ISA at 5 bits

`endif

//--- common/exec_pkg.sv
/*
  Shared types of the execute stage.
  Holds the micro-op codes, the operand-3 word with its two
  decodings, and the issue, writeback and squash payloads.
  Modules import it inside their bodies.
*/

`include "exec_defines.svh"

package exec_pkg;

  // ----------------------------------------------------------
  // Micro-op codes
  // ----------------------------------------------------------

  // ALU class first, then control flow
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_ADDI = 4'd5,
    OP_JAL  = 4'd6,
    OP_JALR = 4'd7,
    OP_BNE  = 4'd8,
    OP_BEQ  = 4'd9
  } exec_uop_e;

  // ----------------------------------------------------------
  // Operand 3, one word seen two ways
  // ----------------------------------------------------------

  typedef union packed {
    // Full branch offset, control-flow unit
    logic [`EXEC_XLEN-1:0] branch_imm;
    // Low 12 bits as the I-type immediate, ALU
    struct packed {
      logic [`EXEC_XLEN-13:0] unused;
      logic [11:0]            imm12;
    } alu;
  } exec_op3_u;

  // ----------------------------------------------------------
  // Stream payloads
  // ----------------------------------------------------------

  // Micro-op from decode/rename
  typedef struct packed {
    logic [`EXEC_XLEN-1:0]           pc;
    logic [`EXEC_SEQ_NUM_BITS-1:0]   seq_num;
    logic [`EXEC_XLEN-1:0]           op1;
    logic [`EXEC_XLEN-1:0]           op2;
    exec_op3_u                       op3;
    logic [4:0]                      waddr;
    exec_uop_e                       uop;
    logic [`EXEC_PHYS_ADDR_BITS-1:0] preg;
    logic [`EXEC_PHYS_ADDR_BITS-1:0] ppreg;
  } exec_issue_t;

  // Result toward writeback
  typedef struct packed {
    logic [`EXEC_XLEN-1:0]           pc;
    logic [`EXEC_SEQ_NUM_BITS-1:0]   seq_num;
    logic [4:0]                      waddr;
    logic                            wen;
    logic [`EXEC_XLEN-1:0]           wdata;
    logic [`EXEC_PHYS_ADDR_BITS-1:0] preg;
    logic [`EXEC_PHYS_ADDR_BITS-1:0] ppreg;
  } exec_wb_t;

  // Taken-branch notification, no ready
  typedef struct packed {
    logic [`EXEC_XLEN-1:0]         target;
    logic [`EXEC_SEQ_NUM_BITS-1:0] seq_num;
  } exec_squash_t;

endpackage

//--- execute/alu_unit.sv
/*
  Arithmetic/logic execute unit for ADD, SUB, AND, OR, XOR and ADDI.
  Holds one micro-op and computes its result from the held operands.
  Always writes the destination register.
*/

`timescale 1ns/1ns

`include "exec_defines.svh"

module alu_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_val,
  input  exec_pkg::exec_issue_t in,
  output logic                  in_rdy,
  output logic                  out_val,
  input  logic                  out_rdy,
  output exec_pkg::exec_wb_t    out
);

  import exec_pkg::*;

  exec_issue_t           op_q;
  logic                  op_val;
  logic                  in_xfer;
  logic                  out_xfer;
  logic [`EXEC_XLEN-1:0] imm_sext;
  logic [`EXEC_XLEN-1:0] result;

  // ----------------------------------------------------------
  // Holding register
  // ----------------------------------------------------------

  assign in_xfer  = in_val & in_rdy;
  assign out_xfer = out_val & out_rdy;
  assign in_rdy   = out_rdy | ~op_val;
  assign out_val  = op_val;

  always_ff @(posedge clk) begin
    if (rst) begin
      op_val <= 1'b0;
    end else if (in_xfer) begin
      op_val <= 1'b1;
    end else if (out_xfer) begin
      op_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_xfer) begin
      op_q <= in;
    end
  end

  // ----------------------------------------------------------
  // Datapath
  // ----------------------------------------------------------

  // I-type immediate, sign extended
  assign imm_sext = {{(`EXEC_XLEN-12){op_q.op3.alu.imm12[11]}}, op_q.op3.alu.imm12};

  always_comb begin
    case (op_q.uop)
      OP_ADD:  result = op_q.op1 + op_q.op2;
      OP_SUB:  result = op_q.op1 - op_q.op2;
      OP_AND:  result = op_q.op1 & op_q.op2;
      OP_OR:   result = op_q.op1 | op_q.op2;
      OP_XOR:  result = op_q.op1 ^ op_q.op2;
      OP_ADDI: result = op_q.op1 + imm_sext;
      default: result = '0;
    endcase
  end

  assign out = '{pc: op_q.pc, seq_num: op_q.seq_num, waddr: op_q.waddr, wen: 1'b1,
                 wdata: result, preg: op_q.preg, ppreg: op_q.ppreg};

  // Dispatch must only route ALU opcodes here
  assert property (@(posedge clk) disable iff (rst)
    out_val |-> op_q.uop inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI});

endmodule

//--- execute/control_flow_unit.sv
/*
  Control-flow execute unit for JAL, JALR, BNE and BEQ.
  Holds one micro-op. Jumps write the link address pc + 4;
  a taken branch sends a one-cycle squash with target pc + offset.
  Fetch already redirected jumps, so they never squash.
*/

`timescale 1ns/1ns

`include "exec_defines.svh"

module control_flow_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_val,
  input  exec_pkg::exec_issue_t in,
  output logic                  in_rdy,
  output logic                  out_val,
  input  logic                  out_rdy,
  output exec_pkg::exec_wb_t    out,
  output logic                  squash_val,
  output exec_pkg::exec_squash_t squash
);

  import exec_pkg::*;

  localparam logic [`EXEC_XLEN-1:0] link_offset = 4;

  // Held micro-op, offset already pulled out of op3
  typedef struct packed {
    logic [`EXEC_XLEN-1:0]           pc;
    logic [`EXEC_SEQ_NUM_BITS-1:0]   seq_num;
    logic [`EXEC_XLEN-1:0]           op1;
    logic [`EXEC_XLEN-1:0]           op2;
    logic [`EXEC_XLEN-1:0]           imm;
    logic [4:0]                      waddr;
    exec_uop_e                       uop;
    logic [`EXEC_PHYS_ADDR_BITS-1:0] preg;
    logic [`EXEC_PHYS_ADDR_BITS-1:0] ppreg;
  } cf_hold_t;

  cf_hold_t hold;
  logic     hold_val;
  logic     in_xfer;
  logic     out_xfer;
  logic     taken;
  logic     squash_sent;

  // ----------------------------------------------------------
  // Holding register
  // ----------------------------------------------------------

  assign in_xfer  = in_val & in_rdy;
  assign out_xfer = out_val & out_rdy;

  // Accept when empty or when the result leaves this cycle
  assign in_rdy  = out_rdy | ~hold_val;
  assign out_val = hold_val;

  always_ff @(posedge clk) begin
    if (rst) begin
      hold_val <= 1'b0;
    end else if (in_xfer) begin
      hold_val <= 1'b1;
    end else if (out_xfer) begin
      hold_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_xfer) begin
      hold <= '{pc: in.pc, seq_num: in.seq_num, op1: in.op1, op2: in.op2,
                imm: in.op3.branch_imm, waddr: in.waddr, uop: in.uop,
                preg: in.preg, ppreg: in.ppreg};
    end
  end

  // ----------------------------------------------------------
  // Branch resolution and squash
  // ----------------------------------------------------------

  always_comb begin
    case (hold.uop)
      OP_BNE:  taken = (hold.op1 != hold.op2);
      OP_BEQ:  taken = (hold.op1 == hold.op2);
      default: taken = 1'b0;
    endcase
  end

  // Cleared by a new acceptance, set one cycle later
  always_ff @(posedge clk) begin
    if (rst) begin
      squash_sent <= 1'b0;
    end else begin
      squash_sent <= ~in_xfer;
    end
  end

  // Pulse only in the first held cycle, regardless of back-pressure
  assign squash_val     = hold_val & taken & ~squash_sent;
  assign squash.target  = hold.pc + hold.imm;
  assign squash.seq_num = hold.seq_num;

  // ----------------------------------------------------------
  // Writeback payload
  // ----------------------------------------------------------

  // Link write for jumps only
  assign out.wen     = (hold.uop == OP_JAL) | (hold.uop == OP_JALR);
  assign out.wdata   = hold.pc + link_offset;
  assign out.pc      = hold.pc;
  assign out.seq_num = hold.seq_num;
  assign out.waddr   = hold.waddr;
  assign out.preg    = hold.preg;
  assign out.ppreg   = hold.ppreg;

  // One squash per branch, unless the next op is accepted meanwhile
  assert property (@(posedge clk) disable iff (rst)
    squash_val && !in_xfer |=> !squash_val);

  // A result only exists after an acceptance or while still held
  assert property (@(posedge clk) disable iff (rst)
    out_val |-> $past(in_xfer) || $past(out_val));

endmodule

//--- execute/exec_dispatch.sv
/*
  Steers each issued micro-op to the ALU or the control-flow unit.
  Purely combinational. The payload is shared by both units and only
  the valid of the selected unit is raised; issue ready follows the
  ready of that unit.
*/

`timescale 1ns/1ns

module exec_dispatch (
  input  logic                 issue_val,
  input  exec_pkg::exec_issue_t issue,
  input  logic                 alu_rdy,
  input  logic                 cf_rdy,
  output logic                 issue_rdy,
  output logic                 alu_val,
  output logic                 cf_val,
  output exec_pkg::exec_issue_t op
);

  import exec_pkg::*;

  logic is_alu;
  logic is_cf;

  // ----------------------------------------------------------
  // Opcode class
  // ----------------------------------------------------------

  always_comb begin
    is_alu = 1'b0;
    is_cf  = 1'b0;
    case (issue.uop)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI: is_alu = 1'b1;
      OP_JAL, OP_JALR, OP_BNE, OP_BEQ:                is_cf  = 1'b1;
      default: begin
        is_alu = 1'b0;
        is_cf  = 1'b0;
      end
    endcase
  end

  // ----------------------------------------------------------
  // Steering
  // ----------------------------------------------------------

  assign alu_val = issue_val & is_alu;
  assign cf_val  = issue_val & is_cf;

  // Ready of whichever unit the opcode selects
  assign issue_rdy = is_cf ? cf_rdy : alu_rdy;

  // Both units see the same payload
  assign op = issue;

  // Decode must hit exactly one unit or the op is lost
  always_comb begin
    if (issue_val) begin
      assert (is_alu ^ is_cf)
        else $error("issued uop %0d belongs to no execute unit", issue.uop);
    end
  end

endmodule

//--- execute/writeback_arbiter.sv
/*
  Merges the ALU and control-flow result streams onto one
  writeback port. Round-robin when both are valid; the
  last-granted pointer moves only on a writeback transfer.
*/

`timescale 1ns/1ns

module writeback_arbiter (
  input  logic               clk,
  input  logic               rst,
  input  logic               alu_val,
  output logic               alu_rdy,
  input  exec_pkg::exec_wb_t alu_wb,
  input  logic               cf_val,
  output logic               cf_rdy,
  input  exec_pkg::exec_wb_t cf_wb,
  output logic               wb_val,
  input  logic               wb_rdy,
  output exec_pkg::exec_wb_t wb
);

  import exec_pkg::*;

  logic last_cf;
  logic grant_alu;
  logic grant_cf;

  // ----------------------------------------------------------
  // Grant
  // ----------------------------------------------------------

  // Control flow wins if alone, or if the ALU went last
  assign grant_cf  = cf_val & (~alu_val | ~last_cf);
  assign grant_alu = alu_val & ~grant_cf;

  assign wb_val  = alu_val | cf_val;
  assign alu_rdy = grant_alu & wb_rdy;
  assign cf_rdy  = grant_cf & wb_rdy;

  always_comb begin
    if (grant_cf) begin
      wb = cf_wb;
    end else begin
      wb = alu_wb;
    end
  end

  // ----------------------------------------------------------
  // Last-granted pointer
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      last_cf <= 1'b0;
    end else if (wb_val && wb_rdy) begin
      last_cf <= grant_cf;
    end
  end

  // Only one unit may see ready
  assert property (@(posedge clk) disable iff (rst) !(alu_rdy && cf_rdy));

  // A waiting control-flow result goes next after an ALU transfer
  assert property (@(posedge clk) disable iff (rst)
    alu_val && cf_val && alu_rdy |=> grant_cf);

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator.
# Exits 0 only when the build and run succeed and the log holds no failure.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --assert --top-module tb_execute -f verilog.f \
  --Mdir "$build_dir" -o tb_execute
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/tb_execute" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Something failed" "$log"; then
  echo "Simulation reported a failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

//--- src/execute_top.sv
/*
  Execute stage top level.
  Issue enters dispatch, goes to the ALU or the control-flow unit,
  and both results meet again in the writeback arbiter. Squash
  leaves straight from the control-flow unit.
*/

`timescale 1ns/1ns

module execute_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   issue_val,
  output logic                   issue_rdy,
  input  exec_pkg::exec_issue_t  issue,
  output logic                   wb_val,
  input  logic                   wb_rdy,
  output exec_pkg::exec_wb_t     wb,
  output logic                   squash_val,
  output exec_pkg::exec_squash_t squash
);

  import exec_pkg::*;

  // Dispatch to units
  exec_issue_t disp_op;
  logic        alu_in_val;
  logic        alu_in_rdy;
  logic        cf_in_val;
  logic        cf_in_rdy;

  // Units to arbiter
  exec_wb_t    alu_out;
  logic        alu_out_val;
  logic        alu_out_rdy;
  exec_wb_t    cf_out;
  logic        cf_out_val;
  logic        cf_out_rdy;

  exec_dispatch u_dispatch (.issue_val(issue_val), .issue(issue), .alu_rdy(alu_in_rdy),
    .cf_rdy(cf_in_rdy), .issue_rdy(issue_rdy), .alu_val(alu_in_val), .cf_val(cf_in_val),
    .op(disp_op));

  alu_unit u_alu (.clk(clk), .rst(rst), .in_val(alu_in_val), .in(disp_op),
    .in_rdy(alu_in_rdy), .out_val(alu_out_val), .out_rdy(alu_out_rdy), .out(alu_out));

  control_flow_unit u_cf (.clk(clk), .rst(rst), .in_val(cf_in_val), .in(disp_op),
    .in_rdy(cf_in_rdy), .out_val(cf_out_val), .out_rdy(cf_out_rdy), .out(cf_out),
    .squash_val(squash_val), .squash(squash));

  writeback_arbiter u_arb (.clk(clk), .rst(rst), .alu_val(alu_out_val),
    .alu_rdy(alu_out_rdy), .alu_wb(alu_out), .cf_val(cf_out_val), .cf_rdy(cf_out_rdy),
    .cf_wb(cf_out), .wb_val(wb_val), .wb_rdy(wb_rdy), .wb(wb));

endmodule

//--- test/tb_execute.sv
/*
  Directed testbench for the execute stage.
  Drives micro-ops on the falling edge and samples all outputs 3 ns
  later. Writebacks and squashes are checked against a model of the
  stage rules held in per-unit scoreboard queues.
*/

`timescale 1ns/1ns

module tb_execute;

  import exec_pkg::*;

  localparam int half_period  = 4;
  localparam int sample_delay = 3;
  localparam int stall_limit  = 40;
  localparam int drain_limit  = 60;
  localparam int random_ops   = 40;

  // Cycle budget per test summed for the watchdog
  localparam int reset_cycles  = 4;
  localparam int alu_cycles    = 30;
  localparam int jump_cycles   = 20;
  localparam int branch_cycles = 30;
  localparam int bp_cycles     = 40;
  localparam int random_cycles = random_ops * 6 + 20;
  localparam int watchdog_ns   = (reset_cycles + alu_cycles + jump_cycles + branch_cycles +
                                  bp_cycles + random_cycles) * 2 * half_period * 3;

  logic         clk;
  logic         rst;
  logic         issue_val;
  logic         issue_rdy;
  exec_issue_t  issue;
  logic         wb_val;
  logic         wb_rdy;
  exec_wb_t     wb;
  logic         squash_val;
  exec_squash_t squash;

  // Scoreboard queue per unit since order across units is free
  exec_wb_t     alu_q[$];
  exec_wb_t     cf_q[$];
  exec_squash_t squash_exp;
  logic         squash_due;

  logic [15:0]  op_lfsr;
  logic [15:0]  rdy_lfsr;
  logic [1:0]   rdy_mode;
  logic [5:0]   next_seq;
  int           errors;
  int           errors_at_start;
  int           tests_run;
  int           tests_failed;

  execute_top u_dut (.clk(clk), .rst(rst), .issue_val(issue_val), .issue_rdy(issue_rdy),
    .issue(issue), .wb_val(wb_val), .wb_rdy(wb_rdy), .wb(wb), .squash_val(squash_val),
    .squash(squash));

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // ----------------------------------------------------------
  // Random bits
  // ----------------------------------------------------------

  // 16-bit Galois LFSR with taps 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // n bits from the stimulus LFSR with one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      op_lfsr = lfsr_next(op_lfsr);
      v = {v[30:0], op_lfsr[0]};
    end
    return v;
  endfunction

  // ----------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------

  task automatic cmp_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic cmp_wb(input exec_wb_t got, input exec_wb_t exp);
    exec_wb_t seen;
    seen = got;
    // wdata is a don't-care when nothing is written
    if (!exp.wen) seen.wdata = exp.wdata;
    if (seen !== exp) begin
      $display("Error at %0t ns: wb got %h expected %h", $time, got, exp);
      errors++;
    end
  endtask

  task automatic cmp_squash(input exec_squash_t got, input exec_squash_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: squash got %h expected %h", $time, got, exp);
      errors++;
    end
  endtask

  // ----------------------------------------------------------
  // Reference model and monitor
  // ----------------------------------------------------------

  // Expected result of one accepted micro-op
  task automatic record_issue(input exec_issue_t op);
    exec_wb_t exp;
    exp.pc      = op.pc;
    exp.seq_num = op.seq_num;
    exp.waddr   = op.waddr;
    exp.preg    = op.preg;
    exp.ppreg   = op.ppreg;
    exp.wen     = 1'b1;
    exp.wdata   = op.pc + 32'd4;
    case (op.uop)
      OP_ADD:  exp.wdata = op.op1 + op.op2;
      OP_SUB:  exp.wdata = op.op1 - op.op2;
      OP_AND:  exp.wdata = op.op1 & op.op2;
      OP_OR:   exp.wdata = op.op1 | op.op2;
      OP_XOR:  exp.wdata = op.op1 ^ op.op2;
      OP_ADDI: exp.wdata = op.op1 + {{20{op.op3.alu.imm12[11]}}, op.op3.alu.imm12};
      OP_BNE, OP_BEQ: begin
        exp.wen = 1'b0;
        squash_due = (op.uop == OP_BNE) ? (op.op1 != op.op2) : (op.op1 == op.op2);
        squash_exp.target  = op.pc + op.op3.branch_imm;
        squash_exp.seq_num = op.seq_num;
      end
      default: exp.wen = 1'b1;
    endcase
    if (op.uop inside {OP_JAL, OP_JALR, OP_BNE, OP_BEQ}) cf_q.push_back(exp);
    else alu_q.push_back(exp);
  endtask

  // Result must be the oldest pending op of its unit
  task automatic match_writeback(input exec_wb_t got);
    exec_wb_t exp;
    if (alu_q.size() != 0 && alu_q[0].seq_num == got.seq_num) begin
      exp = alu_q.pop_front();
      cmp_wb(got, exp);
    end else if (cf_q.size() != 0 && cf_q[0].seq_num == got.seq_num) begin
      exp = cf_q.pop_front();
      cmp_wb(got, exp);
    end else begin
      $display("At %0t ns a writeback with seq_num %0d matched no pending micro-op",
               $time, got.seq_num);
      errors++;
    end
  endtask

  // Looks just before each rising edge
  task automatic monitor_outputs();
    forever begin
      @(negedge clk);
      #sample_delay;
      if (!rst) begin
        cmp_bit("squash_val", squash_val, squash_due);
        if (squash_due && squash_val) cmp_squash(squash, squash_exp);
        squash_due = 1'b0;
        if (wb_val && wb_rdy) match_writeback(wb);
        if (issue_val && issue_rdy) record_issue(issue);
      end
    end
  endtask

  // wb_rdy held low, held high, or random at about 3 in 4
  task automatic drive_wb_rdy();
    logic b0;
    logic b1;
    forever begin
      @(negedge clk);
      if (rdy_mode == 2'd0) begin
        wb_rdy = 1'b0;
      end else if (rdy_mode == 2'd1) begin
        wb_rdy = 1'b1;
      end else begin
        rdy_lfsr = lfsr_next(rdy_lfsr);
        b0 = rdy_lfsr[0];
        rdy_lfsr = lfsr_next(rdy_lfsr);
        b1 = rdy_lfsr[0];
        wb_rdy = b0 | b1;
      end
    end
  endtask

  // ----------------------------------------------------------
  // Drivers
  // ----------------------------------------------------------

  function automatic exec_issue_t make_op(input exec_uop_e uop, input logic [31:0] op1,
                                          input logic [31:0] op2, input logic [31:0] imm);
    exec_issue_t op;
    op.pc               = 32'h0000_1000 + {24'd0, next_seq, 2'b00};
    op.seq_num          = next_seq;
    op.op1              = op1;
    op.op2              = op2;
    op.op3.branch_imm   = imm;
    op.waddr            = next_seq[4:0];
    op.uop              = uop;
    op.preg             = next_seq + 6'd1;
    op.ppreg            = ~next_seq;
    next_seq            = next_seq + 6'd1;
    return op;
  endfunction

  function automatic exec_issue_t random_op();
    exec_issue_t op;
    logic [31:0] v;
    v  = take_bits(4);
    op = make_op(exec_uop_e'(v[3:0] % 4'd10), 32'd0, 32'd0, 32'd0);
    v  = take_bits(30);
    op.pc  = {v[29:0], 2'b00};
    op.op1 = take_bits(32);
    v  = take_bits(1);
    // Equal operands half the time so branches go both ways
    if (v[0]) op.op2 = op.op1;
    else op.op2 = take_bits(32);
    op.op3.branch_imm = take_bits(32);
    return op;
  endfunction

  // Called on a falling edge and returns on the one after acceptance
  task automatic wait_accept();
    int waited;
    waited = 0;
    #sample_delay;
    while (!issue_rdy && waited < stall_limit) begin
      @(negedge clk);
      #sample_delay;
      waited++;
    end
    if (!issue_rdy) begin
      $display("At %0t ns micro-op seq_num %0d was never accepted", $time, issue.seq_num);
      errors++;
    end
    @(negedge clk);
    issue_val = 1'b0;
  endtask

  task automatic send_op(input exec_issue_t op);
    issue_val = 1'b1;
    issue     = op;
    wait_accept();
  endtask

  task automatic set_rdy_mode(input logic [1:0] mode);
    #sample_delay;
    rdy_mode = mode;
    @(negedge clk);
  endtask

  task automatic wait_drain(input string what);
    int waited;
    waited = 0;
    while ((alu_q.size() != 0 || cf_q.size() != 0) && waited < drain_limit) begin
      @(negedge clk);
      waited++;
    end
    if (alu_q.size() != 0 || cf_q.size() != 0) begin
      $display("%s: %0d results were never written back", what, alu_q.size() + cf_q.size());
      errors++;
      alu_q.delete();
      cf_q.delete();
    end
    // Room for a stray squash or extra writeback to show
    repeat (2) @(negedge clk);
  endtask

  // ----------------------------------------------------------
  // Tests
  // ----------------------------------------------------------

  task automatic test_reset_values();
    #sample_delay;
    cmp_bit("issue_rdy", issue_rdy, 1'b1);
    cmp_bit("wb_val", wb_val, 1'b0);
    cmp_bit("squash_val", squash_val, 1'b0);
    @(negedge clk);
  endtask

  task automatic test_alu_ops();
    send_op(make_op(OP_ADD, 32'h7fff_ffff, 32'h0000_0001, 32'd0));
    send_op(make_op(OP_SUB, 32'h0000_0005, 32'h0000_0009, 32'd0));
    send_op(make_op(OP_AND, 32'hf0f0_1234, 32'h0ff0_ff00, 32'd0));
    send_op(make_op(OP_OR, 32'h1200_0034, 32'h0056_7800, 32'd0));
    send_op(make_op(OP_XOR, 32'haaaa_5555, 32'hffff_0000, 32'd0));
    // imm12 of -10 with junk above and then +2047
    send_op(make_op(OP_ADDI, 32'h0000_0100, 32'hdead_beef, 32'habcd_eff6));
    send_op(make_op(OP_ADDI, 32'hffff_fff0, 32'd0, 32'h0000_07ff));
    wait_drain("ALU");
  endtask

  task automatic test_jumps();
    send_op(make_op(OP_JAL, 32'd1, 32'd2, 32'h0000_0100));
    send_op(make_op(OP_JALR, 32'd3, 32'd3, 32'hffff_fff8));
    send_op(make_op(OP_ADD, 32'd4, 32'd5, 32'd0));
    wait_drain("jumps");
  endtask

  task automatic test_branches();
    send_op(make_op(OP_BNE, 32'd1, 32'd2, 32'h0000_0040));
    send_op(make_op(OP_BNE, 32'd9, 32'd9, 32'h0000_0040));
    send_op(make_op(OP_BEQ, 32'h55, 32'h55, 32'hffff_fff0));
    send_op(make_op(OP_BEQ, 32'h55, 32'h56, 32'hffff_fff0));
    // Two taken back to back that each squash once
    send_op(make_op(OP_BEQ, 32'd0, 32'd0, 32'h0000_0800));
    send_op(make_op(OP_BNE, 32'd0, 32'd1, 32'h0000_0010));
    wait_drain("branches");
  endtask

  task automatic test_backpressure();
    set_rdy_mode(2'd0);
    send_op(make_op(OP_ADD, 32'd10, 32'd20, 32'd0));
    send_op(make_op(OP_BEQ, 32'd7, 32'd7, 32'h0000_0040));
    issue_val = 1'b1;
    issue     = make_op(OP_SUB, 32'd50, 32'd8, 32'd0);
    // Both units full and results parked
    repeat (6) begin
      #sample_delay;
      cmp_bit("issue_rdy", issue_rdy, 1'b0);
      cmp_bit("wb_val", wb_val, 1'b1);
      @(negedge clk);
    end
    set_rdy_mode(2'd1);
    wait_accept();
    wait_drain("back-pressure");
  endtask

  task automatic test_random();
    set_rdy_mode(2'd2);
    repeat (random_ops) begin
      send_op(random_op());
      if (take_bits(1) == 32'd1) @(negedge clk);
    end
    set_rdy_mode(2'd1);
    wait_drain("random mix");
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != errors_at_start) begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, errors - errors_at_start);
    end else begin
      $display("Test %s passed", name);
    end
    errors_at_start = errors;
  endtask

  // ----------------------------------------------------------
  // Sequence
  // ----------------------------------------------------------

  initial begin
    rst             = 1'b1;
    issue_val       = 1'b0;
    issue           = '0;
    wb_rdy          = 1'b1;
    rdy_mode        = 2'd1;
    squash_due      = 1'b0;
    squash_exp      = '0;
    op_lfsr         = 16'd61094;
    rdy_lfsr        = 16'd61094;
    next_seq        = '0;
    errors          = 0;
    errors_at_start = 0;
    tests_run       = 0;
    tests_failed    = 0;
    fork
      monitor_outputs();
      drive_wb_rdy();
    join_none
    // Two rising edges in reset, released on the falling edge after
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset_values();
    end_test("reset values");
    test_alu_ops();
    end_test("ALU operations");
    test_jumps();
    end_test("jumps");
    test_branches();
    end_test("branches");
    test_backpressure();
    end_test("back-pressure");
    test_random();
    end_test("random mix");
    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
    $display("Something failed");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+common
common/exec_pkg.sv
execute/exec_dispatch.sv
execute/control_flow_unit.sv
execute/alu_unit.sv
execute/writeback_arbiter.sv
src/execute_top.sv
test/tb_execute.sv
